//--- src/cpuSettings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// word and address width
`define DATA_WIDTH 32

`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

//--- src/cpuPkg.sv
package cpuPkg;

    typedef enum logic [3:0] {
        stFetch          = 4'h0,
        stDecode         = 4'h1,
        stMemAddr        = 4'h2,
        stMemRead        = 4'h3,
        stWriteBack      = 4'h4,
        stMemWrite       = 4'h5,
        stExecute        = 4'h6,
        stRCompletion    = 4'h7,
        stBranchEq       = 4'h8,
        stJumpCompletion = 4'h9,
        stBranchNe       = 4'hA,
        stImmExecute     = 4'hB,
        stImmCompletion  = 4'hC,
        stReset          = 4'hF
    } ctrlState_e;

    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opAndi  = 6'h0C,
        opOri   = 6'h0D,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2A
    } funct_e;

    // logic immediates pick and or or from the opcode
    typedef enum logic [1:0] {
        aluAdd      = 2'b00,
        aluSub      = 2'b01,
        aluFunct    = 2'b10,
        aluLogicImm = 2'b11
    } aluOp_e;

    typedef enum logic [1:0] {
        pcAluResult  = 2'b00,
        pcAluOutReg  = 2'b01,
        pcJumpTarget = 2'b10
    } pcSrc_e;

    typedef enum logic [1:0] {
        brNone = 2'b00,
        brEq   = 2'b01,
        brNe   = 2'b10
    } branchCond_e;

endpackage

//--- src/multiCycleControl.sv
`timescale 1ns/10ps

module multiCycleControl (
    input  logic                clk,
    input  logic                rst,
    input  cpuPkg::opcode_e     opcode,
    input  cpuPkg::funct_e      funct,
    input  logic                pready,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic                pcWrite,
    output cpuPkg::branchCond_e branchCond,
    output cpuPkg::pcSrc_e      pcSource,
    output logic                irWrite,
    output logic                iorD,
    output logic                memToReg,
    output logic                regDst,
    output logic                regWrite,
    output logic                aluSrcA,
    output logic [1:0]          aluSrcB,
    output cpuPkg::aluOp_e      aluOp
);
    import cpuPkg::*;

    ctrlState_e state;
    ctrlState_e nextState;
    // low in the setup cycle, high in access cycles
    logic       phase;
    logic       busState;
    logic       done;

    assign busState = (state == stFetch) || (state == stMemRead) || (state == stMemWrite);
    assign done     = busState && phase && pready;

    assign psel    = busState;
    assign penable = busState && phase;
    assign pwrite  = (state == stMemWrite);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stReset;
            phase <= 1'b0;
        end else begin
            state <= nextState;
            if (busState && !phase) begin
                phase <= 1'b1;
            end else if (done) begin
                phase <= 1'b0;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stReset:     nextState = stFetch;
            stFetch:     nextState = done ? stDecode : stFetch;
            stDecode: begin
                case (opcode)
                    opRType: begin
                        case (funct)
                            fnAdd, fnSub, fnAnd, fnOr, fnSlt: nextState = stExecute;
                            // unsupported funct is skipped
                            default: nextState = stReset;
                        endcase
                    end
                    opJ:                   nextState = stJumpCompletion;
                    opBeq:                 nextState = stBranchEq;
                    opBne:                 nextState = stBranchNe;
                    opAddi, opAndi, opOri: nextState = stImmExecute;
                    opLw, opSw:            nextState = stMemAddr;
                    default:               nextState = stReset;
                endcase
            end
            stMemAddr:   nextState = (opcode == opSw) ? stMemWrite : stMemRead;
            stMemRead:   nextState = done ? stWriteBack : stMemRead;
            stWriteBack: nextState = stFetch;
            // idle cycle so psel drops before the next fetch
            stMemWrite:  nextState = done ? stReset : stMemWrite;
            stExecute:   nextState = stRCompletion;
            stImmExecute: nextState = stImmCompletion;
            default:     nextState = stFetch;
        endcase
    end

    always_comb begin
        pcWrite    = 1'b0;
        branchCond = brNone;
        pcSource   = pcAluResult;
        irWrite    = 1'b0;
        iorD       = 1'b0;
        memToReg   = 1'b0;
        regDst     = 1'b0;
        regWrite   = 1'b0;
        aluSrcA    = 1'b0;
        aluSrcB    = 2'b00;
        aluOp      = aluAdd;
        case (state)
            stFetch: begin
                // pc + 4
                aluSrcB = 2'b01;
                irWrite = done;
                pcWrite = done;
            end
            stDecode: begin
                // branch target into ALUOut
                aluSrcB = 2'b11;
            end
            stMemAddr, stMemRead, stMemWrite: begin
                // address recomputed each cycle, so ALUOut holds steady
                aluSrcA = 1'b1;
                aluSrcB = 2'b10;
                iorD    = (state != stMemAddr);
            end
            stWriteBack: begin
                regWrite = 1'b1;
                memToReg = 1'b1;
            end
            stExecute: begin
                aluSrcA = 1'b1;
                aluOp   = aluFunct;
            end
            stRCompletion: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            stImmExecute: begin
                aluSrcA = 1'b1;
                aluSrcB = 2'b10;
                aluOp   = (opcode == opAddi) ? aluAdd : aluLogicImm;
            end
            stImmCompletion: begin
                regWrite = 1'b1;
            end
            stBranchEq, stBranchNe: begin
                aluSrcA    = 1'b1;
                aluOp      = aluSub;
                branchCond = (state == stBranchEq) ? brEq : brNe;
                pcSource   = pcAluOutReg;
            end
            stJumpCompletion: begin
                pcWrite  = 1'b1;
                pcSource = pcJumpTarget;
            end
            default: ;
        endcase
    end

endmodule

//--- src/programCounter.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module programCounter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pcWrite,
    input  cpuPkg::branchCond_e    branchCond,
    input  cpuPkg::pcSrc_e         pcSource,
    input  logic                   zero,
    input  logic [`DATA_WIDTH-1:0] aluResult,
    input  logic [`DATA_WIDTH-1:0] aluOut,
    input  logic [25:0]            jumpIndex,
    output logic [`DATA_WIDTH-1:0] pc
);
    import cpuPkg::*;

    logic [`DATA_WIDTH-1:0] nextPc;
    logic                   branchTaken;

    always_comb begin
        case (pcSource)
            pcAluOutReg:  nextPc = aluOut;
            // keeps the region bits of pc + 4
            pcJumpTarget: nextPc = {pc[`DATA_WIDTH-1:28], jumpIndex, 2'b00};
            default:      nextPc = aluResult;
        endcase
    end

    assign branchTaken = ((branchCond == brEq) && zero) || ((branchCond == brNe) && !zero);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (pcWrite || branchTaken) begin
            pc <= nextPc;
        end
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic                       writeEnable,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    output logic [`DATA_WIDTH-1:0]     readDataA,
    output logic [`DATA_WIDTH-1:0]     readDataB
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            // r0 never written, stays zero
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

//--- src/alu.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module alu (
    input  cpuPkg::aluOp_e         aluOp,
    input  cpuPkg::funct_e         funct,
    input  cpuPkg::opcode_e        opcode,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero
);
    import cpuPkg::*;

    logic [`DATA_WIDTH-1:0] sum;
    logic [`DATA_WIDTH-1:0] diff;
    logic [`DATA_WIDTH-1:0] lessThan;

    assign sum      = a + b;
    assign diff     = a - b;
    assign lessThan = {{(`DATA_WIDTH-1){1'b0}}, ($signed(a) < $signed(b))};

    always_comb begin
        case (aluOp)
            aluSub: result = diff;
            aluFunct: begin
                case (funct)
                    fnSub:   result = diff;
                    fnAnd:   result = a & b;
                    fnOr:    result = a | b;
                    fnSlt:   result = lessThan;
                    default: result = sum;
                endcase
            end
            // andi or ori, b is the zero-extended immediate
            aluLogicImm: result = (opcode == opOri) ? (a | b) : (a & b);
            default: result = sum;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- src/cpuDatapath.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module cpuDatapath (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   irWrite,
    input  logic                   iorD,
    input  logic                   aluSrcA,
    input  logic [1:0]             aluSrcB,
    input  cpuPkg::aluOp_e         aluOp,
    input  logic                   memToReg,
    input  logic                   regDst,
    input  logic                   regWrite,
    input  logic [`DATA_WIDTH-1:0] pc,
    input  logic [`DATA_WIDTH-1:0] prdata,
    output logic [`DATA_WIDTH-1:0] paddr,
    output logic [`DATA_WIDTH-1:0] pwdata,
    output cpuPkg::opcode_e        opcode,
    output cpuPkg::funct_e         funct,
    output logic                   zero,
    output logic [`DATA_WIDTH-1:0] aluResult,
    output logic [`DATA_WIDTH-1:0] aluOut,
    output logic [25:0]            jumpIndex
);
    import cpuPkg::*;

    logic [`DATA_WIDTH-1:0]     ir;
    logic [`DATA_WIDTH-1:0]     mdr;
    logic [`DATA_WIDTH-1:0]     regA;
    logic [`DATA_WIDTH-1:0]     regB;
    logic [`DATA_WIDTH-1:0]     readDataA;
    logic [`DATA_WIDTH-1:0]     readDataB;
    logic [`DATA_WIDTH-1:0]     writeData;
    logic [`REG_ADDR_WIDTH-1:0] writeAddr;
    logic [`DATA_WIDTH-1:0]     immExt;
    logic [`DATA_WIDTH-1:0]     srcA;
    logic [`DATA_WIDTH-1:0]     srcB;

    assign opcode    = opcode_e'(ir[31:26]);
    assign funct     = funct_e'(ir[5:0]);
    assign jumpIndex = ir[25:0];

    // zero extension for the logic immediates
    assign immExt = ((opcode == opAndi) || (opcode == opOri)) ?
                    {{(`DATA_WIDTH-16){1'b0}}, ir[15:0]} :
                    {{(`DATA_WIDTH-16){ir[15]}}, ir[15:0]};

    always_ff @(posedge clk) begin
        if (irWrite) begin
            ir <= prdata;
        end
        mdr    <= prdata;
        regA   <= readDataA;
        regB   <= readDataB;
        aluOut <= aluResult;
    end

    assign writeAddr = regDst ? ir[15:11] : ir[20:16];
    assign writeData = memToReg ? mdr : aluOut;

    regFile regFile_i (
        .clk        (clk),
        .rst        (rst),
        .readAddrA  (ir[25:21]),
        .readAddrB  (ir[20:16]),
        .writeAddr  (writeAddr),
        .writeEnable(regWrite),
        .writeData  (writeData),
        .readDataA  (readDataA),
        .readDataB  (readDataB)
    );

    assign srcA = aluSrcA ? regA : pc;

    always_comb begin
        case (aluSrcB)
            2'b00:   srcB = regB;
            2'b01:   srcB = `DATA_WIDTH'd4;
            2'b10:   srcB = immExt;
            default: srcB = {immExt[`DATA_WIDTH-3:0], 2'b00};
        endcase
    end

    alu alu_i (
        .aluOp (aluOp),
        .funct (funct),
        .opcode(opcode),
        .a     (srcA),
        .b     (srcB),
        .result(aluResult),
        .zero  (zero)
    );

    assign paddr  = iorD ? aluOut : pc;
    assign pwdata = regB;

endmodule

//--- src/mipsCore.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module mipsCore (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`DATA_WIDTH-1:0] paddr,
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    output logic [`DATA_WIDTH-1:0] pwdata,
    input  logic [`DATA_WIDTH-1:0] prdata,
    input  logic                   pready
);
    import cpuPkg::*;

    opcode_e                opcode;
    funct_e                 funct;
    branchCond_e            branchCond;
    pcSrc_e                 pcSource;
    aluOp_e                 aluOp;
    logic                   pcWrite;
    logic                   irWrite;
    logic                   iorD;
    logic                   memToReg;
    logic                   regDst;
    logic                   regWrite;
    logic                   aluSrcA;
    logic [1:0]             aluSrcB;
    logic                   zero;
    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic [25:0]            jumpIndex;

    multiCycleControl multiCycleControl_i (
        .clk       (clk),
        .rst       (rst),
        .opcode    (opcode),
        .funct     (funct),
        .pready    (pready),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pcWrite   (pcWrite),
        .branchCond(branchCond),
        .pcSource  (pcSource),
        .irWrite   (irWrite),
        .iorD      (iorD),
        .memToReg  (memToReg),
        .regDst    (regDst),
        .regWrite  (regWrite),
        .aluSrcA   (aluSrcA),
        .aluSrcB   (aluSrcB),
        .aluOp     (aluOp)
    );

    programCounter programCounter_i (
        .clk       (clk),
        .rst       (rst),
        .pcWrite   (pcWrite),
        .branchCond(branchCond),
        .pcSource  (pcSource),
        .zero      (zero),
        .aluResult (aluResult),
        .aluOut    (aluOut),
        .jumpIndex (jumpIndex),
        .pc        (pc)
    );

    cpuDatapath cpuDatapath_i (
        .clk      (clk),
        .rst      (rst),
        .irWrite  (irWrite),
        .iorD     (iorD),
        .aluSrcA  (aluSrcA),
        .aluSrcB  (aluSrcB),
        .aluOp    (aluOp),
        .memToReg (memToReg),
        .regDst   (regDst),
        .regWrite (regWrite),
        .pc       (pc),
        .prdata   (prdata),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .opcode   (opcode),
        .funct    (funct),
        .zero     (zero),
        .aluResult(aluResult),
        .aluOut   (aluOut),
        .jumpIndex(jumpIndex)
    );

endmodule

//--- test/coreTb.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module coreTb;

    localparam logic [5:0] rTypeOp = 6'h00;
    localparam logic [5:0] jOp     = 6'h02;
    localparam logic [5:0] beqOp   = 6'h04;
    localparam logic [5:0] bneOp   = 6'h05;
    localparam logic [5:0] addiOp  = 6'h08;
    localparam logic [5:0] andiOp  = 6'h0C;
    localparam logic [5:0] oriOp   = 6'h0D;
    localparam logic [5:0] lwOp    = 6'h23;
    localparam logic [5:0] swOp    = 6'h2B;
    localparam logic [5:0] addFn   = 6'h20;
    localparam logic [5:0] subFn   = 6'h22;
    localparam logic [5:0] andFn   = 6'h24;
    localparam logic [5:0] orFn    = 6'h25;
    localparam logic [5:0] sltFn   = 6'h2A;
    localparam int         dataBase  = 1024;
    localparam logic [31:0] haltAddr = 32'd252;
    localparam int         maxCycles = 5000;
    localparam int         maxIdle   = 8;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    integer      seed = 32'hc5c1_34bc;
    logic [31:0] mem [512];
    logic [31:0] modelMem [512];
    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    logic [31:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    int          haltCount = 0;
    int          storeCount = 0;
    int          modelStoreCount = 0;
    int          idleCycles = 0;
    int          waitLeft = 0;
    bit          inTransfer = 1'b0;
    bit          lastDone = 1'b0;
    logic [31:0] xAddr;
    logic [31:0] xData;
    logic        xWrite;

    mipsCore mipsCore_i (
        .clk    (clk),
        .rst    (rst),
        .paddr  (paddr),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready)
    );

    always #5 clk = ~clk;

    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("Simulation failed");
            $fatal;
        end
    endtask

    task automatic buildProgram();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [5:0]  fn;
        int          maxSkip;
        int          target;
        for (int i = 0; i < 512; i++) begin
            mem[i] = 32'hbad0_0000 | i;
        end
        for (int i = 256; i < 320; i++) begin
            mem[i] = $random(seed);
        end
        // unknown opcode, skipped by the core
        mem[0] = {6'h3F, 26'($random(seed))};
        for (int i = 1; i < 56; i++) begin
            rs = 5'(1 + randBelow(7));
            rt = 5'(1 + randBelow(7));
            rd = 5'(1 + randBelow(7));
            imm = 16'($random(seed));
            // forward targets stay at or below word 56
            maxSkip = (55 - i < 3) ? 55 - i : 3;
            target = i + 1 + int'(randBelow(maxSkip + 1));
            case (randBelow(10))
                0, 1: begin
                    case (randBelow(5))
                        0: fn = addFn;
                        1: fn = subFn;
                        2: fn = andFn;
                        3: fn = orFn;
                        default: fn = sltFn;
                    endcase
                    mem[i] = {rTypeOp, rs, rt, rd, 5'd0, fn};
                end
                2: mem[i] = {addiOp, rs, rt, imm};
                3: mem[i] = {andiOp, rs, rt, imm};
                4: mem[i] = {oriOp, rs, rt, imm};
                5: mem[i] = {lwOp, 5'd0, rt, 16'(dataBase + 4 * randBelow(64))};
                6: mem[i] = {swOp, 5'd0, rt, 16'(dataBase + 4 * randBelow(64))};
                7: mem[i] = {beqOp, rs, rt, 16'(target - i - 1)};
                8: mem[i] = {bneOp, rs, rt, 16'(target - i - 1)};
                default: mem[i] = {jOp, 26'(target)};
            endcase
        end
        // store r1..r7 so every register result reaches the bus
        for (int i = 56; i < 63; i++) begin
            mem[i] = {swOp, 5'd0, 5'(i - 55), 16'(dataBase + 4 * (i - 56))};
        end
        mem[63] = {jOp, 26'(63)};
        for (int i = 0; i < 512; i++) begin
            modelMem[i] = mem[i];
        end
    endtask

    task automatic writeReg(input logic [4:0] r, input logic [31:0] value);
        if (r != 5'd0) begin
            modelRegs[r] = value;
        end
    endtask

    // one instruction of the reference model
    task automatic stepModel();
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] seImm;
        logic [31:0] zeImm;
        logic [31:0] addr;
        instr = modelMem[modelPc[10:2]];
        a = modelRegs[instr[25:21]];
        b = modelRegs[instr[20:16]];
        seImm = {{16{instr[15]}}, instr[15:0]};
        zeImm = {16'h0000, instr[15:0]};
        addr = a + seImm;
        modelPc = modelPc + 32'd4;
        case (instr[31:26])
            rTypeOp: begin
                case (instr[5:0])
                    addFn: writeReg(instr[15:11], a + b);
                    subFn: writeReg(instr[15:11], a - b);
                    andFn: writeReg(instr[15:11], a & b);
                    orFn:  writeReg(instr[15:11], a | b);
                    sltFn: writeReg(instr[15:11], {31'd0, $signed(a) < $signed(b)});
                    default: ;
                endcase
            end
            addiOp: writeReg(instr[20:16], a + seImm);
            andiOp: writeReg(instr[20:16], a & zeImm);
            oriOp:  writeReg(instr[20:16], a | zeImm);
            lwOp:   writeReg(instr[20:16], modelMem[addr[10:2]]);
            swOp: begin
                modelMem[addr[10:2]] = b;
                storeAddrQ.push_back(addr);
                storeDataQ.push_back(b);
                modelStoreCount++;
            end
            beqOp: if (a == b) modelPc = modelPc + {seImm[29:0], 2'b00};
            bneOp: if (a != b) modelPc = modelPc + {seImm[29:0], 2'b00};
            jOp:   modelPc = {modelPc[31:28], instr[25:0], 2'b00};
            default: ;
        endcase
    endtask

    // APB slave and protocol monitor, one call per clock cycle
    task automatic serviceBus();
        pready = 1'b0;
        if (lastDone && psel) begin
            failRun("psel stayed high in the cycle after a completed transfer");
        end
        lastDone = 1'b0;
        if (!psel) begin
            if (penable) begin
                failRun("penable went high without psel");
            end
            if (inTransfer) begin
                failRun("psel dropped before the slave gave pready");
            end
            idleCycles++;
            if (idleCycles > maxIdle) begin
                failRun("no APB transfer started within the idle limit");
            end
        end else if (!penable) begin
            if (inTransfer) begin
                failRun("a second setup cycle came inside a transfer");
            end
            inTransfer = 1'b1;
            idleCycles = 0;
            xAddr = paddr;
            xWrite = pwrite;
            xData = pwdata;
            waitLeft = randBelow(4);
        end else begin
            if (!inTransfer) begin
                failRun("access cycle came without a setup cycle");
            end
            checkValue("paddr", paddr, xAddr);
            checkValue("pwrite", pwrite, xWrite);
            if (xWrite) begin
                checkValue("pwdata", pwdata, xData);
            end
            if (waitLeft > 0) begin
                waitLeft--;
            end else begin
                pready = 1'b1;
                inTransfer = 1'b0;
                lastDone = 1'b1;
                if (xWrite) begin
                    if (storeAddrQ.size() == 0) begin
                        failRun("the core wrote to memory but the model has no store pending");
                    end
                    checkValue("store paddr", xAddr, storeAddrQ.pop_front());
                    checkValue("store pwdata", xData, storeDataQ.pop_front());
                    mem[xAddr[10:2]] = xData;
                    storeCount++;
                end else begin
                    prdata = mem[xAddr[10:2]];
                    // program words sit below the data area
                    if (xAddr < 32'd256) begin
                        checkValue("fetch paddr", xAddr, modelPc);
                        if (xAddr == haltAddr) begin
                            haltCount++;
                        end
                        stepModel();
                    end
                end
            end
        end
    endtask

    initial begin
        int cycles;
        rst = 1'b1;
        pready = 1'b0;
        prdata = '0;
        buildProgram();
        modelPc = `RESET_PC;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            checkValue("psel", psel, 1'b0);
            checkValue("penable", penable, 1'b0);
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        // first setup cycle, a read of the reset PC
        checkValue("psel", psel, 1'b1);
        checkValue("penable", penable, 1'b0);
        checkValue("pwrite", pwrite, 1'b0);
        checkValue("paddr", paddr, `RESET_PC);
        cycles = 0;
        while ((haltCount < 2) && (cycles < maxCycles)) begin
            serviceBus();
            cycles++;
            @(posedge clk);
            #1;
        end
        if (haltCount < 2) begin
            failRun("timeout waiting for the core to fetch the halt loop twice");
        end else begin
            checkValue("storeCount", storeCount, modelStoreCount);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- sim.f
+incdir+src
src/cpuPkg.sv
src/multiCycleControl.sv
src/programCounter.sv
src/regFile.sv
src/alu.sv
src/cpuDatapath.sv
src/mipsCore.sv
test/coreTb.sv
